/* Makefile */
# Verilator build and run for the rvCore testbench
VERILATOR ?= verilator
TOP ?= rvCoreTb
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary -j 0
PASS_TEXT ?= Result: PASSED

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# output goes to the console only, the status comes from the search
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* list.f */
+incdir+verilog
verilog/rvPkg.sv
verilog/coreIfs.sv
verilog/fetchUnit.sv
verilog/regFile.sv
verilog/csrFile.sv
verilog/decoder.sv
verilog/alu.sv
verilog/execStage.sv
verilog/lsuWb.sv
verilog/rvCore.sv
testbench/rvCoreTb.sv

/* testbench/rvCoreTb.sv */
`timescale 1ns/1ps
`include "rv_macros.svh"

module rvCoreTb;

  localparam logic [6:0] opLui = 7'b0110111;
  localparam logic [6:0] opAuipc = 7'b0010111;
  localparam logic [6:0] opJal = 7'b1101111;
  localparam logic [6:0] opJalr = 7'b1100111;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opLoad = 7'b0000011;
  localparam logic [6:0] opStore = 7'b0100011;
  localparam logic [6:0] opImm = 7'b0010011;
  localparam logic [6:0] opReg = 7'b0110011;
  localparam logic [6:0] opSystem = 7'b1110011;

  logic clk;
  logic arstN;
  logic [31:0] imemData;
  logic [31:0] dmemRdata;
  logic dmemReady;
  logic [31:0] imemAddr;
  logic [31:0] dmemAddr;
  logic [31:0] dmemWdata;
  logic [3:0] dmemWmask;
  logic dmemWe;
  logic halted;
  logic retireValid;
  logic [31:0] retirePc;
  logic [4:0] retireRd;
  logic retireWe;
  logic [31:0] retireData;

  // 1 KB of program and 1 KB of data as word arrays
  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:255];

  // reference model state
  logic [31:0] mRegs [0:31];
  logic [31:0] modelMem [0:255];
  logic [31:0] mPc;
  logic [31:0] mMtvec;
  logic [31:0] mMepc;
  logic mHalted;
  int retireCount;

  logic stallPrev;
  logic [31:0] addrPrev;

  rvCore rvCore_i (
    .clk(clk), .arstN(arstN), .imemData(imemData), .dmemRdata(dmemRdata),
    .dmemReady(dmemReady), .imemAddr(imemAddr), .dmemAddr(dmemAddr),
    .dmemWdata(dmemWdata), .dmemWmask(dmemWmask), .dmemWe(dmemWe), .halted(halted),
    .retireValid(retireValid), .retirePc(retirePc), .retireRd(retireRd),
    .retireWe(retireWe), .retireData(retireData)
  );

  always #10 clk = ~clk;

  assign imemData = imem[imemAddr[9:2]];
  assign dmemRdata = dmem[dmemAddr[9:2]];

  function automatic logic [31:0] laneMask(input logic [3:0] m);
    return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
  endfunction

  // byte lanes of a store land on the edge
  always @(posedge clk) begin
    if (arstN && dmemWe) begin
      dmem[dmemAddr[9:2]] <= (dmem[dmemAddr[9:2]] & ~laneMask(dmemWmask)) |
                             (dmemWdata & laneMask(dmemWmask));
    end
  end

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic checkEq(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      failRun($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: return (a < b) ? 32'd1 : 32'd0;
      3'b100: return a ^ b;
      3'b101: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  // one random RV32I instruction with x0 as load and store base
  function automatic logic [31:0] randomInst();
    logic [31:0] r;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] f3;
    logic [11:0] imm;
    logic [12:0] boff;
    logic [20:0] joff;
    int kind;
    r = $urandom();
    rd = r[4:0];
    rs1 = r[9:5];
    rs2 = r[14:10];
    f3 = r[17:15];
    imm = r[29:18];
    kind = $urandom_range(15);
    // short hops of -8 to +8 words
    boff = 13'(($urandom_range(16) * 4) - 32);
    joff = 21'(($urandom_range(16) * 4) - 32);
    case (kind)
      0, 1: return {1'b0, r[30] && (f3 == 3'b000 || f3 == 3'b101), 5'b0, rs2, rs1, f3, rd,
                    opReg};
      2, 3: begin
        if (f3 == 3'b001) begin
          imm = {7'b0, r[22:18]};
        end else if (f3 == 3'b101) begin
          imm = {1'b0, r[30], 5'b0, r[22:18]};
        end
        return {imm, rs1, f3, rd, opImm};
      end
      4: return {r[31:12], rd, opLui};
      5: return {r[31:12], rd, opAuipc};
      6, 7: begin
        if (kind == 7) begin
          f3 = {1'b0, f3[1:0]};
        end
        if (f3 == 3'b011 || f3 == 3'b110 || f3 == 3'b111) begin
          f3 = 3'b010;
        end
        // word index in bits 9..2 and an offset aligned to the access size
        imm = {2'b00, r[27:18]};
        if (f3[1]) begin
          imm[1:0] = 2'b00;
        end else if (f3[0]) begin
          imm[1:0] = {r[19], 1'b0};
        end
        if (kind == 6) begin
          return {imm, 5'd0, f3, rd, opLoad};
        end
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], opStore};
      end
      8, 9: begin
        if (f3 == 3'b010 || f3 == 3'b011) begin
          f3 = 3'b000;
        end
        return {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], opBranch};
      end
      10: return {joff[20], joff[10:1], joff[11], joff[19:12], rd, opJal};
      11: return {imm, rs1, 3'b000, rd, opJalr};
      12, 13: begin
        // mostly the two real CSRs and sometimes one that reads as zero
        imm = r[31] ? `CSR_MTVEC : (r[30] ? `CSR_MEPC : 12'h340);
        f3 = r[15] ? 3'b010 : 3'b001;
        return {imm, rs1, f3, rd, opSystem};
      end
      14: return 32'h0000_0073;
      default: return 32'h3020_0073;
    endcase
  endfunction

  // advance the model by one instruction and compare with the retire port
  task automatic retireOne();
    logic [31:0] inst;
    logic [31:0] rv1;
    logic [31:0] rv2;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immU;
    logic [31:0] immJ;
    logic [31:0] ea;
    logic [31:0] word;
    logic [31:0] result;
    logic [31:0] nextPc;
    logic [31:0] oldCsr;
    logic [31:0] csrVal;
    logic [31:0] storeData;
    logic [6:0] opc;
    logic [2:0] f3;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [11:0] csrNum;
    logic [3:0] mask;
    logic writes;
    logic isStore;
    logic taken;
    inst = imem[mPc[9:2]];
    opc = inst[6:0];
    rd = inst[11:7];
    f3 = inst[14:12];
    rs1 = inst[19:15];
    csrNum = inst[31:20];
    rv1 = mRegs[rs1];
    rv2 = mRegs[inst[24:20]];
    immI = {{20{inst[31]}}, inst[31:20]};
    immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    immU = {inst[31:12], 12'b0};
    immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    nextPc = mPc + 32'd4;
    result = '0;
    writes = 1'b0;
    isStore = 1'b0;
    mask = 4'b0000;
    storeData = '0;
    ea = '0;
    checkEq("retirePc", mPc, retirePc);
    case (opc)
      opLui: begin
        result = immU;
        writes = 1'b1;
      end
      opAuipc: begin
        result = mPc + immU;
        writes = 1'b1;
      end
      opJal: begin
        result = mPc + 32'd4;
        nextPc = mPc + immJ;
        writes = 1'b1;
      end
      // jalr drops bit 0 of its target
      opJalr: begin
        result = mPc + 32'd4;
        nextPc = (rv1 + immI) & ~32'd1;
        writes = 1'b1;
      end
      opBranch: begin
        case (f3)
          3'b000: taken = (rv1 == rv2);
          3'b001: taken = (rv1 != rv2);
          3'b100: taken = ($signed(rv1) < $signed(rv2));
          3'b101: taken = ($signed(rv1) >= $signed(rv2));
          3'b110: taken = (rv1 < rv2);
          default: taken = (rv1 >= rv2);
        endcase
        if (taken) begin
          nextPc = mPc + immB;
        end
      end
      opLoad: begin
        ea = rv1 + immI;
        word = modelMem[ea[9:2]] >> {ea[1:0], 3'b000};
        case (f3)
          3'b000: result = {{24{word[7]}}, word[7:0]};
          3'b001: result = {{16{word[15]}}, word[15:0]};
          3'b100: result = {24'b0, word[7:0]};
          3'b101: result = {16'b0, word[15:0]};
          default: result = word;
        endcase
        writes = 1'b1;
      end
      opStore: begin
        ea = rv1 + immS;
        case (f3)
          3'b000: mask = 4'b0001 << ea[1:0];
          3'b001: mask = 4'b0011 << ea[1:0];
          default: mask = 4'b1111;
        endcase
        storeData = rv2 << {ea[1:0], 3'b000};
        isStore = 1'b1;
      end
      opImm: begin
        result = arith(f3, f3 == 3'b101 && inst[30], rv1, immI);
        writes = 1'b1;
      end
      opReg: begin
        result = arith(f3, inst[30], rv1, rv2);
        writes = 1'b1;
      end
      default: begin
        if (f3 == 3'b000) begin
          if (csrNum == 12'h000) begin
            mMepc = mPc;
            nextPc = mMtvec;
          end else if (csrNum == 12'h001) begin
            mHalted = 1'b1;
          end else begin
            nextPc = mMepc;
          end
        end else begin
          oldCsr = (csrNum == `CSR_MTVEC) ? mMtvec : ((csrNum == `CSR_MEPC) ? mMepc : '0);
          result = oldCsr;
          writes = 1'b1;
          csrVal = (f3 == 3'b001) ? rv1 : (oldCsr | rv1);
          // csrrs with x0 as source leaves the CSR alone
          if (f3 == 3'b001 || rs1 != 5'd0) begin
            if (csrNum == `CSR_MTVEC) begin
              mMtvec = csrVal;
            end else if (csrNum == `CSR_MEPC) begin
              mMepc = csrVal;
            end
          end
        end
      end
    endcase
    checkEq("retireWe", 32'(writes), 32'(retireWe));
    if (writes) begin
      checkEq("retireRd", 32'(rd), 32'(retireRd));
      checkEq("retireData", result, retireData);
    end
    checkEq("dmemWe", 32'(isStore), 32'(dmemWe));
    if (isStore) begin
      checkEq("dmemAddr", {ea[31:2], 2'b00}, dmemAddr);
      checkEq("dmemWmask", 32'(mask), 32'(dmemWmask));
      checkEq("dmemWdata", storeData & laneMask(mask), dmemWdata & laneMask(mask));
      modelMem[ea[9:2]] = (modelMem[ea[9:2]] & ~laneMask(mask)) | (storeData & laneMask(mask));
    end
    if (writes && rd != 5'd0) begin
      mRegs[rd] = result;
    end
    mPc = nextPc;
    retireCount++;
  endtask

  // outputs are settled mid cycle
  always @(negedge clk) begin
    if (arstN) begin
      if (stallPrev) begin
        checkEq("imemAddr held in stall", addrPrev, imemAddr);
      end
      if (!dmemReady) begin
        checkEq("retireValid in stall", 32'd0, 32'(retireValid));
        checkEq("dmemWe in stall", 32'd0, 32'(dmemWe));
      end
      if (mHalted) begin
        checkEq("halted after ebreak", 32'd1, 32'(halted));
        checkEq("retireValid after ebreak", 32'd0, 32'(retireValid));
      end else begin
        checkEq("halted before ebreak", 32'd0, 32'(halted));
        if (dmemReady) begin
          checkEq("retireValid when ready", 32'd1, 32'(retireValid));
        end
        if (retireValid) begin
          retireOne();
        end
      end
      stallPrev = !dmemReady;
      addrPrev = imemAddr;
    end
  end

  initial begin
    int idle;
    int lastCount;
    logic [31:0] fill;
    void'($urandom(32'h0534_4713));
    clk = 1'b0;
    arstN = 1'b0;
    // memory ready while reset is held
    dmemReady = 1'b1;
    retireCount = 0;
    mHalted = 1'b0;
    stallPrev = 1'b0;
    addrPrev = '0;
    mPc = `RESET_PC;
    mMtvec = '0;
    mMepc = '0;
    for (int i = 0; i < 32; i++) begin
      mRegs[i] = '0;
    end
    for (int i = 0; i < 255; i++) begin
      imem[i] = randomInst();
    end
    // ebreak as the last word
    imem[255] = 32'h0010_0073;
    for (int i = 0; i < 256; i++) begin
      fill = $urandom();
      dmem[i] <= fill;
      modelMem[i] = fill;
    end

    repeat (16) @(posedge clk);
    #2;
    checkEq("reset imemAddr", `RESET_PC, imemAddr);
    checkEq("reset retireValid", 32'd0, 32'(retireValid));
    checkEq("reset retireWe", 32'd0, 32'(retireWe));
    checkEq("reset dmemWe", 32'd0, 32'(dmemWe));
    checkEq("reset halted", 32'd0, 32'(halted));
    arstN = 1'b1;

    idle = 0;
    lastCount = 0;
    while (retireCount < 2000 && !mHalted) begin
      @(posedge clk);
      #2;
      // memory stalls about a quarter of the cycles
      dmemReady = ($urandom_range(3) != 0);
      if (retireCount != lastCount) begin
        idle = 0;
        lastCount = retireCount;
      end else begin
        idle++;
        if (idle >= 5000) begin
          failRun("timeout: no instruction retired for 5000 cycles");
        end
      end
    end

    // watch the halted core for a while
    if (mHalted) begin
      for (int i = 0; i < 20; i++) begin
        @(posedge clk);
        #2;
        dmemReady = ($urandom_range(3) != 0);
      end
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ps

module alu import rvPkg::*; (
  input logic [31:0] a,
  input logic [31:0] b,
  input aluOpE op,
  input logic [31:0] rdata1,
  input logic [31:0] rdata2,
  input logic brUn,
  output logic [31:0] result,
  output logic brEq,
  output logic brLt
);

  always_comb begin
    case (op)
      aluAdd: result = a + b;
      aluSub: result = a - b;
      aluSll: result = a << b[4:0];
      aluSlt: result = {31'b0, $signed(a) < $signed(b)};
      aluSltu: result = {31'b0, a < b};
      aluXor: result = a ^ b;
      aluSrl: result = a >> b[4:0];
      aluSra: result = $signed(a) >>> b[4:0];
      aluOr: result = a | b;
      aluAnd: result = a & b;
      aluPassB: result = b;
      default: result = '0;
    endcase
  end

  // branch comparator works on the register values, not the ALU operands
  assign brEq = (rdata1 == rdata2);
  assign brLt = brUn ? (rdata1 < rdata2) : ($signed(rdata1) < $signed(rdata2));

endmodule

/* verilog/coreIfs.sv */
`timescale 1ns/1ps

// fetch unit to decode/execute
interface fetchIf import rvPkg::*; ();
  logic valid;
  logic ready;
  logic [31:0] pc;
  instWordU inst;
  logic [31:0] nextPc;

  modport fetch (output valid, pc, inst, input ready, nextPc);
  modport exec (input valid, pc, inst, output ready, nextPc);
endinterface

// decode/execute to load/store and write-back
interface memStageIf import rvPkg::*; ();
  logic valid;
  logic ready;
  logic memRead;
  logic memWrite;
  memSizeE memSize;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [3:0] wmask;
  wbSelE wbSel;
  logic [31:0] aluOut;
  logic [31:0] csrData;
  logic [31:0] snpc;
  logic [4:0] rd;
  logic regWrite;
  logic [31:0] pc;
  logic ebreak;

  modport exec (
    output valid, memRead, memWrite, memSize, addr, wdata, wmask, wbSel,
    output aluOut, csrData, snpc, rd, regWrite, pc, ebreak,
    input ready
  );
  modport lsu (
    input valid, memRead, memWrite, memSize, addr, wdata, wmask, wbSel,
    input aluOut, csrData, snpc, rd, regWrite, pc, ebreak,
    output ready
  );
endinterface

/* verilog/csrFile.sv */
`timescale 1ns/1ps
`include "rv_macros.svh"

module csrFile (
  input logic clk,
  input logic arstN,
  input logic [11:0] csrId,
  input logic csrWe,
  input logic [31:0] csrWdata,
  input logic ecall,
  input logic [31:0] pc,
  output logic [31:0] csrRdata,
  output logic [31:0] mtvec,
  output logic [31:0] mepc
);

  // unknown numbers read as zero
  always_comb begin
    case (csrId)
      `CSR_MTVEC: csrRdata = mtvec;
      `CSR_MEPC: csrRdata = mepc;
      default: csrRdata = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mtvec <= '0;
      mepc <= '0;
    end else begin
      if (csrWe && csrId == `CSR_MTVEC) begin
        mtvec <= csrWdata;
      end
      // trap entry saves the pc of the ecall itself
      if (ecall) begin
        mepc <= pc;
      end else if (csrWe && csrId == `CSR_MEPC) begin
        mepc <= csrWdata;
      end
    end
  end

endmodule

/* verilog/decoder.sv */
`timescale 1ns/1ps

module decoder import rvPkg::*; (
  input instWordU inst,
  output immSelE immSel,
  output aluOpE aluOp,
  output logic aluAsel,
  output logic [1:0] aluBsel,
  output wbSelE wbSel,
  output logic regWrite,
  output logic memRead,
  output logic memWrite,
  output logic brUn,
  output logic isBranch,
  output logic isJump,
  output logic csrEn,
  output logic csrSet,
  output logic ecall,
  output logic mret,
  output logic ebreak,
  output memSizeE memSize
);

  logic [2:0] funct3;
  logic alt;

  assign funct3 = inst.regView.funct3;
  assign alt = inst.regView.funct7[5];

  // funct3 to ALU op, alt picks sub or sra
  function automatic aluOpE arithOp(input logic [2:0] f3, input logic altOp);
    case (f3)
      3'b000: return altOp ? aluSub : aluAdd;
      3'b001: return aluSll;
      3'b010: return aluSlt;
      3'b011: return aluSltu;
      3'b100: return aluXor;
      3'b101: return altOp ? aluSra : aluSrl;
      3'b110: return aluOr;
      default: return aluAnd;
    endcase
  endfunction

  always_comb begin
    immSel = immI;
    aluOp = aluAdd;
    aluAsel = 1'b0;
    aluBsel = 2'b01;
    wbSel = wbAlu;
    regWrite = 1'b0;
    memRead = 1'b0;
    memWrite = 1'b0;
    brUn = funct3[1];
    isBranch = 1'b0;
    isJump = 1'b0;
    csrEn = 1'b0;
    csrSet = 1'b0;
    ecall = 1'b0;
    mret = 1'b0;
    ebreak = 1'b0;
    memSize = memSizeE'(funct3);
    case (inst.regView.opcode)
      opLui: begin
        immSel = immU;
        aluOp = aluPassB;
        regWrite = 1'b1;
      end
      opAuipc: begin
        immSel = immU;
        aluAsel = 1'b1;
        regWrite = 1'b1;
      end
      // link value is snpc, target comes from the ALU
      opJal: begin
        immSel = immJ;
        aluAsel = 1'b1;
        isJump = 1'b1;
        wbSel = wbSnpc;
        regWrite = 1'b1;
      end
      opJalr: begin
        isJump = 1'b1;
        wbSel = wbSnpc;
        regWrite = 1'b1;
      end
      opBranch: begin
        immSel = immB;
        aluAsel = 1'b1;
        isBranch = 1'b1;
      end
      opLoad: begin
        memRead = 1'b1;
        wbSel = wbMem;
        regWrite = 1'b1;
      end
      opStore: begin
        immSel = immS;
        memWrite = 1'b1;
      end
      opImm: begin
        aluOp = arithOp(funct3, alt && funct3 == 3'b101);
        regWrite = 1'b1;
      end
      opReg: begin
        aluOp = arithOp(funct3, alt);
        aluBsel = 2'b00;
        regWrite = 1'b1;
      end
      opSystem: begin
        if (funct3 == 3'b000) begin
          case (inst.immView.immHi)
            12'h000: ecall = 1'b1;
            12'h001: ebreak = 1'b1;
            12'h302: mret = 1'b1;
            default: ;
          endcase
        end else if (funct3 == 3'b001 || funct3 == 3'b010) begin
          // csrrs value is rs1 | old csr out of the ALU
          csrEn = 1'b1;
          csrSet = (funct3 == 3'b010);
          aluOp = aluOr;
          aluBsel = 2'b10;
          wbSel = wbCsr;
          regWrite = 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

/* verilog/execStage.sv */
`timescale 1ns/1ps

module execStage import rvPkg::*; (
  input logic clk,
  input logic arstN,
  input logic [31:0] regData1,
  input logic [31:0] regData2,
  input logic [31:0] csrReadData,
  input logic [31:0] mtvec,
  input logic [31:0] mepc,
  output logic [4:0] rs1,
  output logic [4:0] rs2,
  output logic [11:0] csrId,
  output logic csrWe,
  output logic [31:0] csrWriteData,
  output logic ecallFire,
  output logic [31:0] pcOut,
  fetchIf.exec fetch,
  memStageIf.exec mem
);

  instWordU inst;
  immSelE immSel;
  aluOpE aluOp;
  wbSelE wbSel;
  memSizeE memSize;
  logic aluAsel;
  logic [1:0] aluBsel;
  logic regWrite, memRead, memWrite, brUn, isBranch, isJump;
  logic csrEn, csrSet, ecall, mret, ebreak;
  logic brEq, brLt, brTaken, fire, stopped;
  logic [31:0] imm, aluA, aluB, aluOut, snpc;

  assign inst = fetch.inst;
  assign rs1 = inst.regView.rs1;
  assign rs2 = inst.regView.rs2;
  assign pcOut = fetch.pc;
  assign snpc = fetch.pc + 32'd4;

  decoder decoder_i (
    .inst(inst), .immSel(immSel), .aluOp(aluOp), .aluAsel(aluAsel), .aluBsel(aluBsel),
    .wbSel(wbSel), .regWrite(regWrite), .memRead(memRead), .memWrite(memWrite),
    .brUn(brUn), .isBranch(isBranch), .isJump(isJump), .csrEn(csrEn), .csrSet(csrSet),
    .ecall(ecall), .mret(mret), .ebreak(ebreak), .memSize(memSize)
  );

  // immediates rebuilt from the immediate view
  always_comb begin
    case (immSel)
      immS: imm = {{20{inst.immView.immHi[11]}}, inst.immView.immHi[11:5], inst.immView.rdOrImm};
      immB: imm = {{20{inst.immView.immHi[11]}}, inst.immView.rdOrImm[0],
                   inst.immView.immHi[10:5], inst.immView.rdOrImm[4:1], 1'b0};
      immU: imm = {inst.immView.immHi, inst.immView.immMid, 12'b0};
      immJ: imm = {{12{inst.immView.immHi[11]}}, inst.immView.immMid,
                   inst.immView.immHi[0], inst.immView.immHi[10:1], 1'b0};
      default: imm = {{20{inst.immView.immHi[11]}}, inst.immView.immHi};
    endcase
  end

  assign aluA = aluAsel ? fetch.pc : regData1;
  always_comb begin
    case (aluBsel)
      2'b00: aluB = regData2;
      2'b01: aluB = imm;
      2'b10: aluB = csrReadData;
      default: aluB = '0;
    endcase
  end

  alu alu_i (
    .a(aluA), .b(aluB), .op(aluOp), .rdata1(regData1), .rdata2(regData2),
    .brUn(brUn), .result(aluOut), .brEq(brEq), .brLt(brLt)
  );

  always_comb begin
    case (inst.regView.funct3)
      3'b000: brTaken = isBranch && brEq;
      3'b001: brTaken = isBranch && !brEq;
      3'b100, 3'b110: brTaken = isBranch && brLt;
      3'b101, 3'b111: brTaken = isBranch && !brLt;
      default: brTaken = 1'b0;
    endcase
  end

  // trap return first, then trap entry, then taken branch or jump
  always_comb begin
    if (mret) begin
      fetch.nextPc = mepc;
    end else if (ecall) begin
      fetch.nextPc = mtvec;
    end else if (brTaken || isJump) begin
      // only jalr clears bit 0 of the target
      fetch.nextPc = {aluOut[31:1], aluOut[0] && aluAsel};
    end else begin
      fetch.nextPc = snpc;
    end
  end

  // nothing after ebreak leaves this stage
  assign fetch.ready = mem.ready && !stopped;
  assign fire = fetch.valid && fetch.ready;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      stopped <= 1'b0;
    end else if (fire && ebreak) begin
      stopped <= 1'b1;
    end
  end

  // csr side effects only with the handshake
  assign csrId = inst.immView.immHi;
  assign csrWriteData = csrSet ? aluOut : regData1;
  assign csrWe = csrEn && fire && (!csrSet || rs1 != 5'd0);
  assign ecallFire = ecall && fire;

  assign mem.valid = fetch.valid && !stopped;
  assign mem.memRead = memRead;
  assign mem.memWrite = memWrite;
  assign mem.memSize = memSize;
  assign mem.addr = aluOut;
  assign mem.wdata = regData2;
  // byte lanes before alignment to the address
  assign mem.wmask = (memSize[1:0] == 2'b00) ? 4'b0001 :
                     (memSize[1:0] == 2'b01) ? 4'b0011 : 4'b1111;
  assign mem.wbSel = wbSel;
  assign mem.aluOut = aluOut;
  assign mem.csrData = csrReadData;
  assign mem.snpc = snpc;
  assign mem.rd = inst.regView.rd;
  assign mem.regWrite = regWrite;
  assign mem.pc = fetch.pc;
  assign mem.ebreak = ebreak;

endmodule

/* verilog/fetchUnit.sv */
`timescale 1ns/1ps
`include "rv_macros.svh"

module fetchUnit (
  input logic clk,
  input logic arstN,
  input logic [31:0] imemData,
  input logic halt,
  output logic [31:0] imemAddr,
  output logic halted,
  fetchIf.fetch fetch
);

  logic [31:0] pc;

  // memory is read in the same cycle, so the word goes straight out
  assign imemAddr = pc;
  assign fetch.pc = pc;
  assign fetch.inst = imemData;
  // nothing is offered while reset is held
  assign fetch.valid = arstN && !halted;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc <= `RESET_PC;
      halted <= 1'b0;
    end else begin
      // pc only moves when the instruction is taken
      if (fetch.valid && fetch.ready) begin
        pc <= fetch.nextPc;
      end
      // sticky once ebreak retires
      if (halt) begin
        halted <= 1'b1;
      end
    end
  end

endmodule

/* verilog/lsuWb.sv */
`timescale 1ns/1ps

module lsuWb import rvPkg::*; (
  input logic clk,
  input logic arstN,
  input logic [31:0] dmemRdata,
  input logic dmemReady,
  output logic [31:0] dmemAddr,
  output logic [31:0] dmemWdata,
  output logic [3:0] dmemWmask,
  output logic dmemWe,
  output logic halt,
  output logic regWe,
  output logic [4:0] regRd,
  output logic [31:0] regWdata,
  output logic retireValid,
  output logic [31:0] retirePc,
  output logic [4:0] retireRd,
  output logic [31:0] retireData,
  output logic retireWe,
  memStageIf.lsu mem
);

  logic fire;
  logic haltHeld;
  logic [1:0] byteOff;
  logic [31:0] loadWord;
  logic [31:0] loadData;
  logic [31:0] wbData;

  // memory stall holds the whole core
  assign mem.ready = dmemReady && !haltHeld;
  assign fire = mem.valid && mem.ready;

  assign byteOff = mem.addr[1:0];
  // word address on the bus, quiet when no access
  assign dmemAddr = (mem.memRead || mem.memWrite) ? {mem.addr[31:2], 2'b00} : '0;
  assign dmemWdata = mem.wdata << {byteOff, 3'b000};
  assign dmemWmask = mem.wmask << byteOff;
  assign dmemWe = fire && mem.memWrite;

  // addressed byte or half moved down to bit 0
  assign loadWord = dmemRdata >> {byteOff, 3'b000};
  always_comb begin
    case (mem.memSize)
      memByte: loadData = {{24{loadWord[7]}}, loadWord[7:0]};
      memHalf: loadData = {{16{loadWord[15]}}, loadWord[15:0]};
      memByteU: loadData = {24'b0, loadWord[7:0]};
      memHalfU: loadData = {16'b0, loadWord[15:0]};
      default: loadData = loadWord;
    endcase
  end

  always_comb begin
    case (mem.wbSel)
      wbMem: wbData = loadData;
      wbSnpc: wbData = mem.snpc;
      wbCsr: wbData = mem.csrData;
      default: wbData = mem.aluOut;
    endcase
  end

  assign regWe = fire && mem.regWrite;
  assign regRd = mem.rd;
  assign regWdata = wbData;

  assign halt = fire && mem.ebreak;
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      haltHeld <= 1'b0;
    end else if (halt) begin
      haltHeld <= 1'b1;
    end
  end

  assign retireValid = fire;
  assign retirePc = mem.pc;
  assign retireRd = mem.rd;
  assign retireData = wbData;
  assign retireWe = regWe;

endmodule

/* verilog/regFile.sv */
`timescale 1ns/1ps
`include "rv_macros.svh"

module regFile (
  input logic clk,
  input logic arstN,
  input logic [4:0] rs1,
  input logic [4:0] rs2,
  input logic [4:0] rd,
  input logic we,
  input logic [`XLEN-1:0] wdata,
  output logic [`XLEN-1:0] rdata1,
  output logic [`XLEN-1:0] rdata2
);

  // x0 has no storage
  logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

  assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 1; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

endmodule

/* verilog/rvCore.sv */
`timescale 1ns/1ps

module rvCore (
  input logic clk,
  input logic arstN,
  input logic [31:0] imemData,
  input logic [31:0] dmemRdata,
  input logic dmemReady,
  output logic [31:0] imemAddr,
  output logic [31:0] dmemAddr,
  output logic [31:0] dmemWdata,
  output logic [3:0] dmemWmask,
  output logic dmemWe,
  output logic halted,
  output logic retireValid,
  output logic [31:0] retirePc,
  output logic [4:0] retireRd,
  output logic retireWe,
  output logic [31:0] retireData
);

  fetchIf fetchBus ();
  memStageIf memBus ();

  logic halt;
  logic [4:0] rs1, rs2, regRd;
  logic [31:0] regData1, regData2, regWdata;
  logic regWe;
  logic [11:0] csrId;
  logic csrWe, ecallFire;
  logic [31:0] csrWriteData, csrReadData, mtvec, mepc, pcOut;

  fetchUnit fetchUnit_i (
    .clk(clk), .arstN(arstN), .imemData(imemData), .halt(halt),
    .imemAddr(imemAddr), .halted(halted), .fetch(fetchBus.fetch)
  );

  execStage execStage_i (
    .clk(clk), .arstN(arstN), .regData1(regData1), .regData2(regData2),
    .csrReadData(csrReadData), .mtvec(mtvec), .mepc(mepc), .rs1(rs1), .rs2(rs2),
    .csrId(csrId), .csrWe(csrWe), .csrWriteData(csrWriteData), .ecallFire(ecallFire),
    .pcOut(pcOut), .fetch(fetchBus.exec), .mem(memBus.exec)
  );

  regFile regFile_i (
    .clk(clk), .arstN(arstN), .rs1(rs1), .rs2(rs2), .rd(regRd), .we(regWe),
    .wdata(regWdata), .rdata1(regData1), .rdata2(regData2)
  );

  csrFile csrFile_i (
    .clk(clk), .arstN(arstN), .csrId(csrId), .csrWe(csrWe), .csrWdata(csrWriteData),
    .ecall(ecallFire), .pc(pcOut), .csrRdata(csrReadData), .mtvec(mtvec), .mepc(mepc)
  );

  lsuWb lsuWb_i (
    .clk(clk), .arstN(arstN), .dmemRdata(dmemRdata), .dmemReady(dmemReady),
    .dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .dmemWmask(dmemWmask), .dmemWe(dmemWe),
    .halt(halt), .regWe(regWe), .regRd(regRd), .regWdata(regWdata),
    .retireValid(retireValid), .retirePc(retirePc), .retireRd(retireRd),
    .retireData(retireData), .retireWe(retireWe), .mem(memBus.lsu)
  );

endmodule

/* verilog/rvPkg.sv */
package rvPkg;

  // major opcodes of RV32I, fence left out
  typedef enum logic [6:0] {
    opLui = 7'b0110111,
    opAuipc = 7'b0010111,
    opJal = 7'b1101111,
    opJalr = 7'b1100111,
    opBranch = 7'b1100011,
    opLoad = 7'b0000011,
    opStore = 7'b0100011,
    opImm = 7'b0010011,
    opReg = 7'b0110011,
    opSystem = 7'b1110011
  } opcodeE;

  // one instruction word, read as register fields or as immediate fields
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      opcodeE opcode;
    } regView;
    struct packed {
      logic [11:0] immHi;
      logic [7:0] immMid;
      logic [4:0] rdOrImm;
      opcodeE opcode;
    } immView;
  } instWordU;

  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluSll,
    aluSlt,
    aluSltu,
    aluXor,
    aluSrl,
    aluSra,
    aluOr,
    aluAnd,
    aluPassB
  } aluOpE;

  // source of the value written to rd
  typedef enum logic [1:0] {
    wbAlu,
    wbMem,
    wbSnpc,
    wbCsr
  } wbSelE;

  // same coding as funct3 of loads and stores
  typedef enum logic [2:0] {
    memByte = 3'b000,
    memHalf = 3'b001,
    memWord = 3'b010,
    memByteU = 3'b100,
    memHalfU = 3'b101
  } memSizeE;

  typedef enum logic [2:0] {
    immI,
    immS,
    immB,
    immU,
    immJ
  } immSelE;

endpackage

/* verilog/rv_macros.svh */
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// first instruction fetched after reset
`define RESET_PC 32'h0000_0000

// machine trap vector and exception pc
`define CSR_MTVEC 12'h305
`define CSR_MEPC 12'h341

// data path width
`define XLEN 32

// x0 included, hardwired to zero
`define NUM_REGS 32

`endif
